/* Bender.yml */
package:
  name: cu_mem_port

sources:
  - files:
      - hw/cu_mem_pkg.sv
      - hw/sync_fifo.sv
      - hw/request_mapper.sv
      - hw/cmd_issuer.sv
      - hw/scratch_mem.sv
      - hw/cu_mem_port.sv
  - target: simulation
    files:
      - sim/cu_mem_port_tb.sv

/* hw/cmd_issuer.sv */
// Command issuer
// Pops memory requests from the request FIFO, runs one APB
// transfer per request and pushes the result into the
// response FIFO

module cmd_issuer (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          desc_valid_i,
  input  logic                          req_empty_i,
  input  cu_mem_pkg::mem_req_t          req_i,
  input  logic                          rsp_prog_full_i,
  input  logic                          pready_i,
  input  logic [cu_mem_pkg::DATA_W-1:0] prdata_i,
  output logic                          req_pop_o,
  output logic                          rsp_push_o,
  output cu_mem_pkg::mem_rsp_t          rsp_o,
  output logic                          idle_o,
  output logic                          psel_o,
  output logic                          penable_o,
  output logic                          pwrite_o,
  output logic [cu_mem_pkg::ADDR_W-1:0] paddr_o,
  output logic [cu_mem_pkg::DATA_W-1:0] pwdata_o,
  output logic [cu_mem_pkg::STRB_W-1:0] pstrb_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e state_q;
  state_e state_next;
  logic   start;
  logic   done_xfer;
  logic   is_write;

  // --------------------------------------------------
  // Issue conditions
  // --------------------------------------------------
  // Needs a base, a request and room for the result
  assign start     = desc_valid_i & ~req_empty_i & ~rsp_prog_full_i;
  assign done_xfer = (state_q == ST_ACCESS) & pready_i;
  assign is_write  = (req_i.cmd == cu_mem_pkg::CMD_MEM_WRITE);

  // --------------------------------------------------
  // State machine
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  always_comb begin
    state_next = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start) begin
          state_next = ST_SETUP;
        end
      end
      // Exactly one setup cycle
      ST_SETUP: begin
        state_next = ST_ACCESS;
      end
      // Stay until the slave is ready, then one idle cycle
      ST_ACCESS: begin
        if (pready_i) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  assign idle_o = (state_q == ST_IDLE);

  // --------------------------------------------------
  // APB drive
  // --------------------------------------------------
  // FIFO head is not popped until pready, so the
  // address and control hold for the whole transfer
  assign psel_o    = (state_q != ST_IDLE);
  assign penable_o = (state_q == ST_ACCESS);
  assign pwrite_o  = is_write;
  assign paddr_o   = req_i.addr;
  assign pwdata_o  = req_i.wdata;
  assign pstrb_o   = req_i.strb;

  // --------------------------------------------------
  // Completion
  // --------------------------------------------------
  // Pop and push together on the last access cycle
  assign req_pop_o  = done_xfer;
  assign rsp_push_o = done_xfer;

  always_comb begin
    rsp_o.cmd   = req_i.cmd;
    rsp_o.tag   = req_i.tag;
    // Writes report zero data
    rsp_o.rdata = is_write ? '0 : prdata_i;
  end

endmodule : cmd_issuer

/* hw/cu_mem_pkg.sv */
// Compute unit memory front end shared definitions
// Word and tag widths, the request command encoding and
// the payload structs carried by the request and response FIFOs

package cu_mem_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  // One memory word
  localparam int DATA_W = 32;
  // One strobe bit per byte
  localparam int STRB_W = DATA_W / 8;
  // Word address and descriptor base, 1024 words
  localparam int ADDR_W = 10;
  // Request tag echoed back in the response
  localparam int TAG_W  = 8;

  // --------------------------------------------------
  // Command encoding
  // --------------------------------------------------
  typedef enum logic [0:0] {
    CMD_MEM_READ  = 1'b0,
    CMD_MEM_WRITE = 1'b1
  } mem_cmd_e;

  // --------------------------------------------------
  // Request FIFO payload
  // --------------------------------------------------
  // Address already mapped to a physical word address
  typedef struct packed {
    mem_cmd_e            cmd;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
    // All zero for reads
    logic [STRB_W-1:0]   strb;
    logic [TAG_W-1:0]    tag;
  } mem_req_t;

  // --------------------------------------------------
  // Response FIFO payload
  // --------------------------------------------------
  // Read data is zero for a write response
  typedef struct packed {
    mem_cmd_e            cmd;
    logic [TAG_W-1:0]    tag;
    logic [DATA_W-1:0]   rdata;
  } mem_rsp_t;

endpackage : cu_mem_pkg

/* hw/cu_mem_port.sv */
// Compute unit memory port, top level
// Request mapper, request FIFO, APB issuer, scratch memory and
// response FIFO in a chain, plus a registered idle flag

module cu_mem_port #(
  parameter int FIFO_DEPTH  = 16,
  parameter int PROG_THRESH = 12,
  parameter int MEM_WAIT    = 1
) (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          desc_valid_i,
  input  logic [cu_mem_pkg::ADDR_W-1:0] desc_base_i,
  input  logic                          req_valid_i,
  input  cu_mem_pkg::mem_cmd_e          req_cmd_i,
  input  logic [cu_mem_pkg::ADDR_W-1:0] req_index_i,
  input  logic [cu_mem_pkg::DATA_W-1:0] req_wdata_i,
  input  logic [cu_mem_pkg::STRB_W-1:0] req_strb_i,
  input  logic [cu_mem_pkg::TAG_W-1:0]  req_tag_i,
  output logic                          req_ready_o,
  output logic                          rsp_valid_o,
  output cu_mem_pkg::mem_cmd_e          rsp_cmd_o,
  output logic [cu_mem_pkg::TAG_W-1:0]  rsp_tag_o,
  output logic [cu_mem_pkg::DATA_W-1:0] rsp_rdata_o,
  input  logic                          rsp_ready_i,
  output logic                          done_o
);

  // --------------------------------------------------
  // Internal signals
  // --------------------------------------------------
  // Mapper to request FIFO
  logic                          desc_valid;
  logic                          req_push;
  cu_mem_pkg::mem_req_t          req_din;
  logic                          req_full;

  // Request FIFO to issuer
  cu_mem_pkg::mem_req_t          req_head;
  logic                          req_empty;
  logic                          req_pop;

  // Issuer to response FIFO
  logic                          rsp_push;
  cu_mem_pkg::mem_rsp_t          rsp_din;
  logic                          rsp_prog_full;
  cu_mem_pkg::mem_rsp_t          rsp_head;
  logic                          rsp_empty;
  logic                          rsp_pop;
  logic                          issuer_idle;

  // APB
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic [cu_mem_pkg::ADDR_W-1:0] paddr;
  logic [cu_mem_pkg::DATA_W-1:0] pwdata;
  logic [cu_mem_pkg::STRB_W-1:0] pstrb;
  logic                          pready;
  logic [cu_mem_pkg::DATA_W-1:0] prdata;

  // Done pipeline
  logic                          all_idle;
  logic                          done_q1;
  logic                          done_q2;

  request_mapper u_request_mapper (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .desc_valid_i  (desc_valid_i),
    .desc_base_i   (desc_base_i),
    .req_valid_i   (req_valid_i),
    .req_cmd_i     (req_cmd_i),
    .req_index_i   (req_index_i),
    .req_wdata_i   (req_wdata_i),
    .req_strb_i    (req_strb_i),
    .req_tag_i     (req_tag_i),
    .fifo_full_i   (req_full),
    .req_ready_o   (req_ready_o),
    .push_o        (req_push),
    .req_o         (req_din),
    .desc_valid_o  (desc_valid)
  );

  // --------------------------------------------------
  // Request FIFO
  // --------------------------------------------------
  sync_fifo #(
    .payload_t  (cu_mem_pkg::mem_req_t),
    .DEPTH      (FIFO_DEPTH),
    .PROG_THRESH(PROG_THRESH)
  ) u_req_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push_i        (req_push),
    .din_i         (req_din),
    .pop_i         (req_pop),
    .dout_o        (req_head),
    .empty_o       (req_empty),
    .full_o        (req_full),
    .prog_full_o   ()
  );

  cmd_issuer u_cmd_issuer (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .desc_valid_i   (desc_valid),
    .req_empty_i    (req_empty),
    .req_i          (req_head),
    .rsp_prog_full_i(rsp_prog_full),
    .pready_i       (pready),
    .prdata_i       (prdata),
    .req_pop_o      (req_pop),
    .rsp_push_o     (rsp_push),
    .rsp_o          (rsp_din),
    .idle_o         (issuer_idle),
    .psel_o         (psel),
    .penable_o      (penable),
    .pwrite_o       (pwrite),
    .paddr_o        (paddr),
    .pwdata_o       (pwdata),
    .pstrb_o        (pstrb)
  );

  scratch_mem #(
    .MEM_WAIT(MEM_WAIT)
  ) u_scratch_mem (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .paddr_i       (paddr),
    .pwdata_i      (pwdata),
    .pstrb_i       (pstrb),
    .pready_o      (pready),
    .prdata_o      (prdata)
  );

  // --------------------------------------------------
  // Response FIFO
  // --------------------------------------------------
  // Issuer stalls on prog_full, full itself is never reached
  sync_fifo #(
    .payload_t  (cu_mem_pkg::mem_rsp_t),
    .DEPTH      (FIFO_DEPTH),
    .PROG_THRESH(PROG_THRESH)
  ) u_rsp_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push_i        (rsp_push),
    .din_i         (rsp_din),
    .pop_i         (rsp_pop),
    .dout_o        (rsp_head),
    .empty_o       (rsp_empty),
    .full_o        (),
    .prog_full_o   (rsp_prog_full)
  );

  assign rsp_valid_o = ~rsp_empty;
  assign rsp_pop     = rsp_valid_o & rsp_ready_i;
  assign rsp_cmd_o   = rsp_head.cmd;
  assign rsp_tag_o   = rsp_head.tag;
  assign rsp_rdata_o = rsp_head.rdata;

  // --------------------------------------------------
  // Done flag
  // --------------------------------------------------
  // A request still in the mapper register counts as busy
  assign all_idle = req_empty & rsp_empty & issuer_idle & ~req_push;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      done_q1 <= 1'b0;
      done_q2 <= 1'b0;
    end else begin
      done_q1 <= all_idle;
      done_q2 <= done_q1;
    end
  end

  assign done_o = done_q2;

endmodule : cu_mem_port

/* hw/request_mapper.sv */
// Request mapper
// Holds the kernel descriptor base and turns each accepted
// compute unit request into a physical-address memory request

module request_mapper (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          desc_valid_i,
  input  logic [cu_mem_pkg::ADDR_W-1:0] desc_base_i,
  input  logic                          req_valid_i,
  input  cu_mem_pkg::mem_cmd_e          req_cmd_i,
  input  logic [cu_mem_pkg::ADDR_W-1:0] req_index_i,
  input  logic [cu_mem_pkg::DATA_W-1:0] req_wdata_i,
  input  logic [cu_mem_pkg::STRB_W-1:0] req_strb_i,
  input  logic [cu_mem_pkg::TAG_W-1:0]  req_tag_i,
  input  logic                          fifo_full_i,
  output logic                          req_ready_o,
  output logic                          push_o,
  output cu_mem_pkg::mem_req_t          req_o,
  output logic                          desc_valid_o
);

  logic                          desc_valid_q;
  logic [cu_mem_pkg::ADDR_W-1:0] desc_base_q;
  logic                          accept;
  logic                          push_q;
  cu_mem_pkg::mem_req_t          req_next;
  cu_mem_pkg::mem_req_t          req_q;

  // --------------------------------------------------
  // Descriptor register
  // --------------------------------------------------
  // Base stays until the next load pulse
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      desc_valid_q <= 1'b0;
      desc_base_q  <= '0;
    end else if (desc_valid_i) begin
      desc_valid_q <= 1'b1;
      desc_base_q  <= desc_base_i;
    end
  end

  assign desc_valid_o = desc_valid_q;

  // --------------------------------------------------
  // Accept and map
  // --------------------------------------------------
  assign req_ready_o = ~fifo_full_i;
  assign accept      = req_valid_i & req_ready_o;

  always_comb begin
    req_next.cmd   = req_cmd_i;
    // Sum wraps modulo the memory depth
    req_next.addr  = desc_base_q + req_index_i;
    req_next.wdata = req_wdata_i;
    // Reads never carry strobes
    req_next.strb  = (req_cmd_i == cu_mem_pkg::CMD_MEM_WRITE) ? req_strb_i : '0;
    req_next.tag   = req_tag_i;
  end

  // Held while the FIFO is full, ready is low meanwhile
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      push_q <= 1'b0;
    end else begin
      push_q <= accept | (push_q & fifo_full_i);
    end
  end

  always_ff @(posedge ap_clk) begin
    if (accept) begin
      req_q <= req_next;
    end
  end

  assign push_o = push_q;
  assign req_o  = req_q;

endmodule : request_mapper

/* hw/scratch_mem.sv */
// Scratch memory
// APB slave word memory with byte strobes and a fixed
// number of wait states on every transfer

module scratch_mem #(
  parameter int MEM_WAIT = 1
) (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [cu_mem_pkg::ADDR_W-1:0] paddr_i,
  input  logic [cu_mem_pkg::DATA_W-1:0] pwdata_i,
  input  logic [cu_mem_pkg::STRB_W-1:0] pstrb_i,
  output logic                          pready_o,
  output logic [cu_mem_pkg::DATA_W-1:0] prdata_o
);

  localparam int WORDS = 2 ** cu_mem_pkg::ADDR_W;
  localparam int CNT_W = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;

  logic [cu_mem_pkg::DATA_W-1:0] mem_q [WORDS] = '{default: '0};
  logic [cu_mem_pkg::DATA_W-1:0] rdata_q;
  logic [CNT_W-1:0]              wait_q;
  logic                          access;

  // --------------------------------------------------
  // Wait states
  // --------------------------------------------------
  assign access   = psel_i & penable_i;
  assign pready_o = access & (wait_q == CNT_W'(MEM_WAIT));

  // Counts access cycles, cleared between transfers
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wait_q <= '0;
    end else if (access && !pready_o) begin
      wait_q <= wait_q + 1'b1;
    end else begin
      wait_q <= '0;
    end
  end

  // --------------------------------------------------
  // Array access
  // --------------------------------------------------
  // Only the strobed bytes change
  always_ff @(posedge ap_clk) begin
    if (pready_o && pwrite_i) begin
      for (int b = 0; b < cu_mem_pkg::STRB_W; b++) begin
        if (pstrb_i[b]) begin
          mem_q[paddr_i][b*8 +: 8] <= pwdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Address is stable from setup, so read data is ready by pready
  always_ff @(posedge ap_clk) begin
    if (psel_i) begin
      rdata_q <= mem_q[paddr_i];
    end
  end

  assign prdata_o = rdata_q;

endmodule : scratch_mem

/* hw/sync_fifo.sv */
// Show-ahead synchronous FIFO
// Circular buffer with an occupancy count; the head entry is
// visible on dout_o while not empty. Payload type is a parameter

module sync_fifo #(
  parameter type payload_t   = logic [7:0],
  parameter int  DEPTH       = 16,
  parameter int  PROG_THRESH = 12
) (
  input  logic     ap_clk,
  input  logic     areset_control,
  input  logic     push_i,
  input  payload_t din_i,
  input  logic     pop_i,
  output payload_t dout_o,
  output logic     empty_o,
  output logic     full_o,
  output logic     prog_full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------
  payload_t           mem_q [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;

  logic push_ok;
  logic pop_ok;

  // Illegal push or pop is dropped here
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  // Status flags straight from the count
  assign empty_o     = (count_q == '0);
  assign full_o      = (count_q == CNT_W'(DEPTH));
  assign prog_full_o = (count_q >= CNT_W'(PROG_THRESH));

  // Head entry, show-ahead
  assign dout_o = mem_q[rd_ptr_q];

  always_ff @(posedge ap_clk) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= din_i;
    end
  end

  // --------------------------------------------------
  // Pointer and count update
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        // Wrap explicitly, DEPTH need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule : sync_fifo

/* sim/cu_mem_port_tb.sv */
// Testbench for the compute unit memory port
// Drives descriptors and word requests, models the scratch memory
// and the base mapping, and checks every response, the stall before
// the first descriptor, back-pressure and the done flag

module cu_mem_port_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // Request counts per phase
  localparam int N_PRE    = 4;
  localparam int N_RAND   = 40;
  localparam int N_REMAP  = 16;
  localparam int N_BP_MAX = 48;
  localparam int MAX_REQ  = N_PRE + N_RAND + N_REMAP + N_BP_MAX;
  localparam int WATCHDOG_CYCLES = 200 * MAX_REQ + 1000;

  logic                          ap_clk;
  logic                          areset_control;
  logic                          desc_valid_i;
  logic [cu_mem_pkg::ADDR_W-1:0] desc_base_i;
  logic                          req_valid_i;
  cu_mem_pkg::mem_cmd_e          req_cmd_i;
  logic [cu_mem_pkg::ADDR_W-1:0] req_index_i;
  logic [cu_mem_pkg::DATA_W-1:0] req_wdata_i;
  logic [cu_mem_pkg::STRB_W-1:0] req_strb_i;
  logic [cu_mem_pkg::TAG_W-1:0]  req_tag_i;
  logic                          req_ready_o;
  logic                          rsp_valid_o;
  cu_mem_pkg::mem_cmd_e          rsp_cmd_o;
  logic [cu_mem_pkg::TAG_W-1:0]  rsp_tag_o;
  logic [cu_mem_pkg::DATA_W-1:0] rsp_rdata_o;
  logic                          rsp_ready_i;
  logic                          done_o;

  // --------------------------------------------------
  // Reference model state
  // --------------------------------------------------
  logic [cu_mem_pkg::DATA_W-1:0] ref_mem [2 ** cu_mem_pkg::ADDR_W] = '{default: '0};
  cu_mem_pkg::mem_rsp_t          exp_q [$];
  logic [cu_mem_pkg::ADDR_W-1:0] mdl_base;
  logic                          desc_seen;
  // Front of the expected queue as the assertions see it
  logic                          exp_avail;
  cu_mem_pkg::mem_cmd_e          exp_cmd;
  logic [cu_mem_pkg::TAG_W-1:0]  exp_tag;
  logic [cu_mem_pkg::DATA_W-1:0] exp_rdata;
  // Outstanding flag aged to line up with the two-cycle done delay
  logic                          busy_now;
  logic                          busy_d1;
  logic                          busy_d2;
  int                            quiet_cnt;
  logic                          rsp_hs;
  logic                          hold_rsp;
  logic [cu_mem_pkg::TAG_W-1:0]  tag_cnt;
  int                            seed = 17;

  cu_mem_port dut_i (.*);

  assign rsp_hs = rsp_valid_o & rsp_ready_i;

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // --------------------------------------------------
  // Error reporting
  // --------------------------------------------------
  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
    $display("FAILED at %0t: %s expected 0x%08h, actual 0x%08h", $time, name, expv, actv);
    abort_run();
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    abort_run();
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  always @(posedge ap_clk) begin : ref_model
    cu_mem_pkg::mem_rsp_t          rsp;
    logic [cu_mem_pkg::ADDR_W-1:0] addr;
    if (areset_control) begin
      exp_q.delete();
      mdl_base  = '0;
      desc_seen = 1'b0;
    end else begin
      if (rsp_hs && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (req_valid_i && req_ready_o) begin
        // Base as it stood before this edge
        // Address wraps at 1024 words
        addr      = mdl_base + req_index_i;
        rsp.cmd   = req_cmd_i;
        rsp.tag   = req_tag_i;
        rsp.rdata = '0;
        if (req_cmd_i == cu_mem_pkg::CMD_MEM_WRITE) begin
          for (int b = 0; b < cu_mem_pkg::STRB_W; b++) begin
            if (req_strb_i[b]) begin
              ref_mem[addr][b*8 +: 8] = req_wdata_i[b*8 +: 8];
            end
          end
        end else begin
          rsp.rdata = ref_mem[addr];
        end
        exp_q.push_back(rsp);
      end
      if (desc_valid_i) begin
        mdl_base  = desc_base_i;
        desc_seen = 1'b1;
      end
    end
    busy_d2  = busy_d1;
    busy_d1  = busy_now;
    busy_now = (exp_q.size() != 0);
    if (areset_control || req_valid_i || busy_now) begin
      quiet_cnt = 0;
    end else if (quiet_cnt < 1000) begin
      quiet_cnt++;
    end
    exp_avail = busy_now;
    if (exp_avail) begin
      exp_cmd   = exp_q[0].cmd;
      exp_tag   = exp_q[0].tag;
      exp_rdata = exp_q[0].rdata;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // No response beyond what was requested
  a_rsp_known: assert property (@(posedge ap_clk) disable iff (areset_control)
    rsp_hs |-> exp_avail)
    else report_error("response consumed with no request outstanding");

  // Order, command and tag echo
  a_rsp_cmd: assert property (@(posedge ap_clk) disable iff (areset_control)
    rsp_hs && exp_avail |-> rsp_cmd_o == exp_cmd)
    else show_mismatch("rsp_cmd_o", $sampled(exp_cmd), $sampled(rsp_cmd_o));

  a_rsp_tag: assert property (@(posedge ap_clk) disable iff (areset_control)
    rsp_hs && exp_avail |-> rsp_tag_o == exp_tag)
    else show_mismatch("rsp_tag_o", $sampled(exp_tag), $sampled(rsp_tag_o));

  // Strobed memory contents or zero for writes
  a_rsp_rdata: assert property (@(posedge ap_clk) disable iff (areset_control)
    rsp_hs && exp_avail |-> rsp_rdata_o == exp_rdata)
    else show_mismatch("rsp_rdata_o", $sampled(exp_rdata), $sampled(rsp_rdata_o));

  // Nothing is issued without a descriptor
  a_no_early_rsp: assert property (@(posedge ap_clk) disable iff (areset_control)
    !desc_seen |-> !rsp_valid_o)
    else show_mismatch("rsp_valid_o", 32'd0, $sampled(rsp_valid_o));

  a_done_busy: assert property (@(posedge ap_clk) disable iff (areset_control)
    busy_d2 |-> !done_o)
    else show_mismatch("done_o", 32'd0, $sampled(done_o));

  a_done_idle: assert property (@(posedge ap_clk) disable iff (areset_control)
    quiet_cnt >= 10 |-> done_o)
    else show_mismatch("done_o", 32'd1, $sampled(done_o));

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  // Called and returns 1 ns after a rising edge
  task automatic send_req(input cu_mem_pkg::mem_cmd_e cmd,
                          input logic [cu_mem_pkg::ADDR_W-1:0] idx,
                          input logic [cu_mem_pkg::DATA_W-1:0] wdata,
                          input logic [cu_mem_pkg::STRB_W-1:0] strb);
    req_valid_i = 1'b1;
    req_cmd_i   = cmd;
    req_index_i = idx;
    req_wdata_i = wdata;
    req_strb_i  = strb;
    req_tag_i   = tag_cnt;
    do begin
      @(posedge ap_clk);
    end while (!req_ready_o);
    #1;
    req_valid_i = 1'b0;
    tag_cnt++;
  endtask

  // Mixed read or write within a small index window
  task automatic send_random(input int span);
    cu_mem_pkg::mem_cmd_e          cmd;
    logic [cu_mem_pkg::ADDR_W-1:0] idx;
    cmd = ($random(seed) % 2 == 0) ? cu_mem_pkg::CMD_MEM_READ : cu_mem_pkg::CMD_MEM_WRITE;
    idx = ($random(seed) & 32'h7fff_ffff) % span;
    send_req(cmd, idx, $random(seed), $random(seed));
  endtask

  task automatic load_base(input logic [cu_mem_pkg::ADDR_W-1:0] base);
    desc_valid_i = 1'b1;
    desc_base_i  = base;
    @(posedge ap_clk);
    #1;
    desc_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    do begin
      @(posedge ap_clk);
      #1;
    end while (exp_q.size() != 0);
  endtask

  // Random response ready unless held back
  initial begin : rsp_ready_drive
    logic ready_next;
    rsp_ready_i = 1'b0;
    forever begin
      @(posedge ap_clk);
      // Next ready value is chosen on the clock edge
      if (hold_rsp) begin
        ready_next = 1'b0;
      end else begin
        ready_next = ($random(seed) % 4 != 0);
      end
      #1;
      rsp_ready_i = ready_next;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
    $display("Timeout after %0d cycles, responses stopped arriving", WATCHDOG_CYCLES);
    abort_run();
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : main_seq
    logic [cu_mem_pkg::ADDR_W-1:0] base1;
    logic [cu_mem_pkg::ADDR_W-1:0] base2;
    logic                          stall_seen;
    int                            sent;
    areset_control = 1'b1;
    desc_valid_i   = 1'b0;
    desc_base_i    = '0;
    req_valid_i    = 1'b0;
    req_cmd_i      = cu_mem_pkg::CMD_MEM_READ;
    req_index_i    = '0;
    req_wdata_i    = '0;
    req_strb_i     = '0;
    req_tag_i      = '0;
    hold_rsp       = 1'b0;
    tag_cnt        = '0;
    repeat (10) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;
    repeat (3) @(posedge ap_clk);
    #1;

    // Writes before any descriptor use the reset base
    for (int i = 0; i < N_PRE; i++) begin
      send_req(cu_mem_pkg::CMD_MEM_WRITE, i, $random(seed), 4'hf);
    end
    repeat (20) @(posedge ap_clk);
    #1;
    base1 = $random(seed);
    load_base(base1);
    wait_drain();

    // Random strobed traffic under the first base
    for (int i = 0; i < N_RAND; i++) begin
      send_random(16);
    end
    wait_drain();

    // Same physical words read back under a new base
    base2 = base1 + 10'd300;
    load_base(base2);
    for (int i = 0; i < N_REMAP; i++) begin
      send_req(cu_mem_pkg::CMD_MEM_READ, i + base1 - base2, '0, '0);
    end
    wait_drain();

    // Back-pressure with the response side stopped
    hold_rsp = 1'b1;
    @(posedge ap_clk);
    #1;
    stall_seen = 1'b0;
    sent       = 0;
    while (!stall_seen && sent < N_BP_MAX) begin
      if (!req_ready_o) begin
        stall_seen = 1'b1;
      end else begin
        send_random(16);
        sent++;
      end
    end
    assert (stall_seen)
      else report_error("req_ready_o never fell while responses were held back");
    hold_rsp = 1'b0;
    wait_drain();

    // Done must rise in the quiet period
    repeat (12) @(posedge ap_clk);
    #1;
    assert (done_o)
      else report_error("done_o stayed low after all responses were consumed");
    $display("Result: PASSED");
    $finish;
  end

endmodule : cu_mem_port_tb

/* verilog.f */
hw/cu_mem_pkg.sv
hw/sync_fifo.sv
hw/request_mapper.sv
hw/cmd_issuer.sv
hw/scratch_mem.sv
hw/cu_mem_port.sv
sim/cu_mem_port_tb.sv
